//--- cpu.f
source/cpu_pkg.sv
source/mem_req_if.sv
source/mem_lanes.sv
source/register_file.sv
source/fetch_sequencer.sv
source/alu.sv
source/execute_unit.sv
source/cpu.sv
sim/cpu_ref_model.sv
sim/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the cpu testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module cpu_tb -f cpu.f -o cpu_sim
./obj_dir/cpu_sim > sim.log 2>&1
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- sim/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;
	import cpu_ref_model::*;

	localparam word_t RESET_PC = 16'h4000;
	localparam int TIMEOUT = 3000;
	localparam int HOLD_CYCLES = 20;

	logic clk;
	logic reset;
	bank_addr_t read_addr_even;
	bank_addr_t read_addr_odd;
	byte_t read_data_even;
	byte_t read_data_odd;
	bank_addr_t write_addr_even;
	bank_addr_t write_addr_odd;
	byte_t write_data_even;
	byte_t write_data_odd;
	logic write_en_even;
	logic write_en_odd;
	logic trap;

	byte_t bank_even [32768];
	byte_t bank_odd [32768];
	bank_addr_t fetch_even_q;
	bank_addr_t fetch_odd_q;

	integer seed;
	int errors;
	int store_idx;
	int cycles;

	cpu #(.RESET_PC(RESET_PC)) uut (
		.clk(clk),
		.reset(reset),
		.read_addr_even(read_addr_even),
		.read_addr_odd(read_addr_odd),
		.read_data_even(read_data_even),
		.read_data_odd(read_data_odd),
		.write_addr_even(write_addr_even),
		.write_addr_odd(write_addr_odd),
		.write_data_even(write_data_even),
		.write_data_odd(write_data_odd),
		.write_en_even(write_en_even),
		.write_en_odd(write_en_odd),
		.trap(trap)
	);

	always #10 clk = ~clk;

	// banks latch the address at the rising edge, data follows at the falling edge
	always @(posedge clk)
	begin
		fetch_even_q <= read_addr_even;
		fetch_odd_q <= read_addr_odd;
		if (write_en_even)
			bank_even[write_addr_even] <= write_data_even;
		if (write_en_odd)
			bank_odd[write_addr_odd] <= write_data_odd;
	end

	always @(negedge clk)
	begin
		read_data_even <= bank_even[fetch_even_q];
		read_data_odd <= bank_odd[fetch_odd_q];
	end

	// odd byte address: the even bank serves the next word
	function automatic bank_addr_t even_index(word_t a);
		if (a[0])
			return a[15:1] + 15'd1;
		return a[15:1];
	endfunction

	task automatic check_reset_outputs();
		if (write_en_even !== 1'b0 || write_en_odd !== 1'b0)
		begin
			$display("Mismatch write_en during reset: got %h expected 0",
				{write_en_odd, write_en_even});
			errors++;
		end
		if (trap !== 1'b0)
		begin
			$display("Mismatch trap during reset: got %h expected 0", trap);
			errors++;
		end
		if (read_addr_even !== even_index(RESET_PC))
		begin
			$display("Mismatch read_addr_even: got %h expected %h",
				read_addr_even, even_index(RESET_PC));
			errors++;
		end
		if (read_addr_odd !== RESET_PC[15:1])
		begin
			$display("Mismatch read_addr_odd: got %h expected %h",
				read_addr_odd, RESET_PC[15:1]);
			errors++;
		end
	endtask

	task automatic check_store(input word_t addr, input byte_t data);
		if (store_idx >= store_addr.size())
		begin
			$display("Unexpected store of %h to %h after the expected stores ran out",
				data, addr);
			errors++;
		end
		else
		begin
			if (addr !== store_addr[store_idx])
			begin
				$display("Mismatch store %0d write_addr: got %h expected %h",
					store_idx, addr, store_addr[store_idx]);
				errors++;
			end
			if (data !== store_data[store_idx])
			begin
				$display("Mismatch store %0d write_data: got %h expected %h",
					store_idx, data, store_data[store_idx]);
				errors++;
			end
		end
		store_idx++;
	endtask

	// lower byte address first, so a word store comes out low byte first
	task automatic collect_stores();
		word_t even_byte;
		word_t odd_byte;
		even_byte = {write_addr_even, 1'b0};
		odd_byte = {write_addr_odd, 1'b1};
		if (write_en_even && write_en_odd && odd_byte < even_byte)
		begin
			check_store(odd_byte, write_data_odd);
			check_store(even_byte, write_data_even);
		end
		else
		begin
			if (write_en_even)
				check_store(even_byte, write_data_even);
			if (write_en_odd)
				check_store(odd_byte, write_data_odd);
		end
	endtask

	initial
	begin
		seed = 42;
		errors = 0;
		store_idx = 0;
		clk = 1'b0;
		reset = 1'b1;
		read_data_even = 8'h00;
		read_data_odd = 8'h00;

		build_program(seed, RESET_PC);
		for (int i = 0; i < 32768; i++)
		begin
			bank_even[i] = model_mem[{i[14:0], 1'b0}];
			bank_odd[i] = model_mem[{i[14:0], 1'b1}];
		end
		run_model(RESET_PC);

		repeat (8)
		begin
			@(negedge clk);
			check_reset_outputs();
		end
		reset = 1'b0;

		cycles = 0;
		while (!trap && cycles < TIMEOUT)
		begin
			@(posedge clk);
			collect_stores();
			cycles++;
		end

		if (!trap)
		begin
			$display("Timeout: trap did not rise within %0d cycles", TIMEOUT);
			errors++;
		end
		else
		begin
			if (store_idx != store_addr.size())
			begin
				$display("Mismatch store count at trap: got %h expected %h",
					store_idx, store_addr.size());
				errors++;
			end
			repeat (HOLD_CYCLES)
			begin
				@(posedge clk);
				if (trap !== 1'b1)
				begin
					$display("Mismatch trap after trap rose: got %h expected 1", trap);
					errors++;
				end
				if (write_en_even !== 1'b0 || write_en_odd !== 1'b0)
				begin
					$display("Mismatch write_en after trap: got %h expected 0",
						{write_en_odd, write_en_even});
					errors++;
				end
			end
		end

		$display("errors: %0d, stores seen: %0d, stores expected: %0d",
			errors, store_idx, store_addr.size());
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- sim/cpu_ref_model.sv
package cpu_ref_model;
	import cpu_pkg::*;

	localparam int PROG_LEN = 60;
	localparam int STEP_LIMIT = 1000;

	byte_t model_mem [65536];
	word_t store_addr [$];
	byte_t store_data [$];

	function automatic opcode_t pick_opcode(int r);
		case (r)
			0: return OP_NOP;
			1: return OP_INC_XL;
			2: return OP_SRL_XL;
			3: return OP_ADDW_Y_X;
			4: return OP_LD_XL_IMM;
			5: return OP_ADD_XL_IMM;
			6: return OP_SUB_XL_IMM;
			7: return OP_AND_XL_IMM;
			8: return OP_OR_XL_IMM;
			9: return OP_XOR_XL_IMM;
			10: return OP_JR;
			11: return OP_JRZ;
			12: return OP_JRNZ;
			13: return OP_JRC;
			14: return OP_JRNC;
			15: return OP_LD_XL_DIR;
			16, 17: return OP_LD_DIR_XL;
			18: return OP_LDW_Y_IMM;
			default: return OP_LDW_DIR_Y;
		endcase
	endfunction

	function automatic logic is_branch(opcode_t op);
		return op inside {OP_JR, OP_JRZ, OP_JRNZ, OP_JRC, OP_JRNC};
	endfunction

	// 8-bit a + b + cin with half carry, carry and signed overflow
	function automatic byte_t add_byte(byte_t a, byte_t b, logic cin,
		output logic h, output logic c, output logic o);
		logic [4:0] low;
		logic [8:0] full;
		low = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'h0, cin};
		full = {1'b0, a} + {1'b0, b} + {8'h00, cin};
		h = low[4];
		c = full[8];
		o = (a[7] == b[7]) && (full[7] != a[7]);
		return full[7:0];
	endfunction

	function automatic void record_store(word_t addr, byte_t data);
		model_mem[addr] = data;
		store_addr.push_back(addr);
		store_data.push_back(data);
	endfunction

	function automatic void build_program(inout integer seed, input word_t start);
		opcode_t ops [PROG_LEN];
		word_t pc;
		byte_t lo;
		int i;
		for (i = 0; i < 65536; i++)
			model_mem[i] = byte_t'(i) ^ byte_t'(i >> 8) ^ 8'ha5;
		for (i = 'h100; i < 'h200; i++)
			model_mem[i] = byte_t'($random(seed));

		// prefix gives every register and flag a value before use
		ops[0] = OP_LD_XL_IMM;
		ops[1] = OP_LDW_Y_IMM;
		ops[2] = OP_ADD_XL_IMM;
		ops[3] = OP_LDW_DIR_Y;
		ops[4] = OP_LDW_DIR_Y;
		for (i = 5; i < PROG_LEN - 2; i++)
			ops[i] = pick_opcode({$random(seed)} % 20);
		ops[PROG_LEN - 2] = OP_LD_DIR_XL;
		ops[PROG_LEN - 1] = OP_TRAP;

		pc = start;
		for (i = 0; i < PROG_LEN; i++)
		begin
			lo = byte_t'($random(seed));
			// word stores at even and odd dir
			if (i == 3)
				lo[0] = 1'b0;
			else if (i == 4)
				lo[0] = 1'b1;
			model_mem[pc] = ops[i];
			// displacement counts from the branch itself
			if (is_branch(ops[i]))
				model_mem[pc + 16'd1] = 8'd2 + {6'd0, inst_len(ops[i + 1])};
			else
				model_mem[pc + 16'd1] = lo;
			if (ops[i] == OP_LDW_Y_IMM)
				model_mem[pc + 16'd2] = byte_t'($random(seed));
			else
				model_mem[pc + 16'd2] = 8'h01;
			pc = pc + {14'd0, inst_len(ops[i])};
		end
	endfunction

	function automatic void run_model(input word_t start);
		word_t pc;
		word_t x;
		word_t y;
		word_t dir;
		byte_t imm;
		byte_t r;
		logic [16:0] wide;
		logic h;
		logic c;
		logic n;
		logic z;
		logic o;
		logic taken;
		opcode_t op;
		int steps;
		store_addr.delete();
		store_data.delete();
		pc = start;
		// nothing loads the x high byte, taken as zero
		x = 16'h0000;
		y = 16'h0000;
		h = 1'b0;
		c = 1'b0;
		n = 1'b0;
		z = 1'b0;
		o = 1'b0;
		steps = 0;
		op = opcode_t'(model_mem[pc]);
		while (op != OP_TRAP && steps < STEP_LIMIT)
		begin
			imm = model_mem[pc + 16'd1];
			dir = {model_mem[pc + 16'd2], imm};
			taken = 1'b0;
			case (op)
				OP_LD_XL_IMM:
					x[7:0] = imm;
				OP_ADD_XL_IMM, OP_SUB_XL_IMM, OP_INC_XL:
				begin
					if (op == OP_SUB_XL_IMM)
						r = add_byte(x[7:0], ~imm, 1'b1, h, c, o);
					else if (op == OP_INC_XL)
						r = add_byte(x[7:0], 8'h01, 1'b0, h, c, o);
					else
						r = add_byte(x[7:0], imm, 1'b0, h, c, o);
					x[7:0] = r;
					n = r[7];
					z = (r == 8'h00);
				end
				OP_AND_XL_IMM, OP_OR_XL_IMM, OP_XOR_XL_IMM:
				begin
					if (op == OP_AND_XL_IMM)
						r = x[7:0] & imm;
					else if (op == OP_OR_XL_IMM)
						r = x[7:0] | imm;
					else
						r = x[7:0] ^ imm;
					x[7:0] = r;
					n = r[7];
					z = (r == 8'h00);
				end
				OP_SRL_XL:
				begin
					c = x[0];
					x[7:0] = {1'b0, x[7:1]};
					z = (x[7:0] == 8'h00);
				end
				OP_LD_XL_DIR:
				begin
					x[7:0] = model_mem[dir];
					n = x[7];
					z = (x[7:0] == 8'h00);
				end
				OP_LD_DIR_XL:
					record_store(dir, x[7:0]);
				OP_LDW_Y_IMM:
				begin
					y = dir;
					n = y[15];
					z = (y == 16'h0000);
				end
				OP_LDW_DIR_Y:
				begin
					record_store(dir, y[7:0]);
					record_store(dir + 16'd1, y[15:8]);
				end
				OP_ADDW_Y_X:
				begin
					wide = {1'b0, y} + {1'b0, x};
					o = (y[15] == x[15]) && (wide[15] != y[15]);
					y = wide[15:0];
					c = wide[16];
					n = y[15];
					z = (y == 16'h0000);
				end
				OP_JR: taken = 1'b1;
				OP_JRZ: taken = z;
				OP_JRNZ: taken = !z;
				OP_JRC: taken = c;
				OP_JRNC: taken = !c;
				default: ;
			endcase
			if (taken)
				pc = pc + {{8{imm[7]}}, imm};
			else
				pc = pc + {14'd0, inst_len(op)};
			steps++;
			op = opcode_t'(model_mem[pc]);
		end
	endfunction

endpackage

//--- source/cpu.sv
`timescale 1ns/1ps

module cpu #(
	parameter cpu_pkg::word_t RESET_PC = 16'h4000
) (
	input logic clk,
	input logic reset,
	output cpu_pkg::bank_addr_t read_addr_even,
	output cpu_pkg::bank_addr_t read_addr_odd,
	input cpu_pkg::byte_t read_data_even,
	input cpu_pkg::byte_t read_data_odd,
	output cpu_pkg::bank_addr_t write_addr_even,
	output cpu_pkg::bank_addr_t write_addr_odd,
	output cpu_pkg::byte_t write_data_even,
	output cpu_pkg::byte_t write_data_odd,
	output logic write_en_even,
	output logic write_en_odd,
	output logic trap
);
	import cpu_pkg::*;

	inst_t inst;
	word_t operand;
	logic execute;
	word_t x;
	word_t y;
	byte_t f;
	byte_t next_f;
	byte_t alu_f;
	alu_op_t alu_op;
	word_t alu_a;
	word_t alu_b;
	word_t alu_result;
	logic [1:0] reg_addr;
	logic [1:0] reg_en;
	word_t reg_data;

	mem_req_if mem ();

	mem_lanes lanes (
		.clk(clk),
		.mem(mem.lanes),
		.read_addr_even(read_addr_even),
		.read_addr_odd(read_addr_odd),
		.read_data_even(read_data_even),
		.read_data_odd(read_data_odd),
		.write_addr_even(write_addr_even),
		.write_addr_odd(write_addr_odd),
		.write_data_even(write_data_even),
		.write_data_odd(write_data_odd),
		.write_en_even(write_en_even),
		.write_en_odd(write_en_odd)
	);

	fetch_sequencer #(.RESET_PC(RESET_PC)) fetch (
		.clk(clk),
		.reset(reset),
		.mem(mem.fetch),
		.f(f),
		.inst(inst),
		.operand(operand),
		.execute(execute),
		.trap(trap)
	);

	execute_unit exec (
		.execute(execute),
		.inst(inst),
		.operand(operand),
		.x(x),
		.y(y),
		.f(f),
		.mem(mem.exec),
		.alu_op(alu_op),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.alu_result(alu_result),
		.alu_f(alu_f),
		.reg_addr(reg_addr),
		.reg_data(reg_data),
		.reg_en(reg_en),
		.next_f(next_f)
	);

	alu alu_unit (
		.op(alu_op),
		.a(alu_a),
		.b(alu_b),
		.f(f),
		.result(alu_result),
		.next_f(alu_f)
	);

	register_file regs (
		.clk(clk),
		.reset(reset),
		.reg_addr(reg_addr),
		.reg_data(reg_data),
		.reg_en(reg_en),
		.next_f(next_f),
		.x(x),
		.y(y),
		.f(f)
	);

endmodule

//--- source/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
	input logic execute,
	input cpu_pkg::inst_t inst,
	input cpu_pkg::word_t operand,
	input cpu_pkg::word_t x,
	input cpu_pkg::word_t y,
	input cpu_pkg::byte_t f,
	mem_req_if.exec mem,
	output cpu_pkg::alu_op_t alu_op,
	output cpu_pkg::word_t alu_a,
	output cpu_pkg::word_t alu_b,
	input cpu_pkg::word_t alu_result,
	input cpu_pkg::byte_t alu_f,
	output logic [1:0] reg_addr,
	output cpu_pkg::word_t reg_data,
	output logic [1:0] reg_en,
	output cpu_pkg::byte_t next_f
);
	import cpu_pkg::*;

	localparam logic [1:0] REG_X = 2'd0;
	localparam logic [1:0] REG_Y = 2'd1;

	opcode_t opcode;

	assign opcode = opcode_t'(inst[7:0]);

	always_comb
	begin
		case (opcode)
			OP_ADD_XL_IMM: alu_op = ALU_ADD;
			OP_SUB_XL_IMM: alu_op = ALU_SUB;
			OP_AND_XL_IMM: alu_op = ALU_AND;
			OP_OR_XL_IMM: alu_op = ALU_OR;
			OP_XOR_XL_IMM: alu_op = ALU_XOR;
			OP_INC_XL: alu_op = ALU_INC;
			OP_SRL_XL: alu_op = ALU_SRL;
			OP_ADDW_Y_X: alu_op = ALU_ADDW;
			default: alu_op = ALU_PASS;
		endcase

		alu_a = (opcode == OP_ADDW_Y_X) ? y : x;

		// sign-extend the loaded byte so pass yields byte N and Z
		case (opcode)
			OP_ADDW_Y_X: alu_b = x;
			OP_LDW_Y_IMM: alu_b = operand;
			OP_LD_XL_DIR: alu_b = {{8{operand[7]}}, operand[7:0]};
			default: alu_b = {8'h00, operand[7:0]};
		endcase
	end

	always_comb
	begin
		reg_addr = REG_X;
		reg_data = alu_result;
		reg_en = 2'b00;
		next_f = f;
		mem.write_addr = inst[23:8];
		mem.write_data = y;
		mem.write_en = 2'b00;

		if (execute)
		begin
			case (opcode)
				// load immediate leaves the flags alone
				OP_LD_XL_IMM:
					reg_en = 2'b01;
				OP_ADD_XL_IMM, OP_SUB_XL_IMM, OP_AND_XL_IMM, OP_OR_XL_IMM, OP_XOR_XL_IMM,
				OP_INC_XL, OP_SRL_XL, OP_LD_XL_DIR:
				begin
					reg_en = 2'b01;
					next_f = alu_f;
				end
				OP_LDW_Y_IMM, OP_ADDW_Y_X:
				begin
					reg_addr = REG_Y;
					reg_en = 2'b11;
					next_f = alu_f;
				end
				OP_LD_DIR_XL:
				begin
					mem.write_data = {8'h00, x[7:0]};
					mem.write_en = 2'b01;
				end
				OP_LDW_DIR_Y:
					mem.write_en = 2'b11;
				default:
					next_f = f;
			endcase
		end
	end

endmodule

//--- source/alu.sv
`timescale 1ns/1ps

module alu (
	input cpu_pkg::alu_op_t op,
	input cpu_pkg::word_t a,
	input cpu_pkg::word_t b,
	input cpu_pkg::byte_t f,
	output cpu_pkg::word_t result,
	output cpu_pkg::byte_t next_f
);
	import cpu_pkg::*;

	byte_t add_b;
	byte_t r8;
	logic cin;
	logic [4:0] sum4;
	logic [8:0] sum8;
	logic [16:0] sum16;
	logic ovf8;
	logic ovf16;

	// sub is a + ~b + 1, carry out becomes C
	always_comb
	begin
		add_b = b[7:0];
		cin = 1'b0;
		if (op == ALU_SUB)
		begin
			add_b = ~b[7:0];
			cin = 1'b1;
		end
		else if (op == ALU_INC)
			add_b = 8'h01;
	end

	assign sum4 = {1'b0, a[3:0]} + {1'b0, add_b[3:0]} + {4'h0, cin};
	assign sum8 = {1'b0, a[7:0]} + {1'b0, add_b} + {8'h00, cin};
	assign ovf8 = (a[7] == add_b[7]) && (sum8[7] != a[7]);
	assign sum16 = {1'b0, a} + {1'b0, b};
	assign ovf16 = (a[15] == b[15]) && (sum16[15] != a[15]);

	always_comb
	begin
		next_f = f;
		next_f[FLAG_5] = 1'b0;
		next_f[FLAG_6] = 1'b0;
		next_f[FLAG_7] = 1'b0;
		r8 = sum8[7:0];
		case (op)
			ALU_ADD, ALU_SUB, ALU_INC:
			begin
				next_f[FLAG_H] = sum4[4];
				next_f[FLAG_C] = sum8[8];
				next_f[FLAG_O] = ovf8;
			end
			ALU_AND:
				r8 = a[7:0] & b[7:0];
			ALU_OR:
				r8 = a[7:0] | b[7:0];
			ALU_XOR:
				r8 = a[7:0] ^ b[7:0];
			ALU_SRL:
			begin
				r8 = {1'b0, a[7:1]};
				next_f[FLAG_C] = a[0];
			end
			default:
				r8 = 8'h00;
		endcase

		result = {8'h00, r8};
		if (op != ALU_SRL)
			next_f[FLAG_N] = r8[7];
		next_f[FLAG_Z] = (r8 == 8'h00);

		// word ops, byte loads arrive sign-extended
		if (op == ALU_ADDW)
		begin
			result = sum16[15:0];
			next_f[FLAG_C] = sum16[16];
			next_f[FLAG_O] = ovf16;
		end
		else if (op == ALU_PASS)
			result = b;
		if (op == ALU_ADDW || op == ALU_PASS)
		begin
			next_f[FLAG_N] = result[15];
			next_f[FLAG_Z] = (result == 16'h0000);
		end
	end

endmodule

//--- source/fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer #(
	parameter cpu_pkg::word_t RESET_PC = 16'h4000
) (
	input logic clk,
	input logic reset,
	mem_req_if.fetch mem,
	input cpu_pkg::byte_t f,
	output cpu_pkg::inst_t inst,
	output cpu_pkg::word_t operand,
	output logic execute,
	output logic trap
);
	import cpu_pkg::*;

	word_t pc;
	word_t next_pc;
	inst_t saved;
	logic fresh;
	logic upper_pend;
	logic op_pend;
	logic need_upper;
	logic need_operand;
	logic taken;
	opcode_t opcode;

	// fresh: nothing requested yet after reset
	always_comb
	begin
		if (upper_pend)
			inst = {mem.read_data[15:8], saved[15:0]};
		else if (op_pend || fresh)
			inst = saved;
		else
			inst = {8'h00, mem.read_data};
	end

	assign opcode = opcode_t'(inst[7:0]);
	assign operand = op_pend ? mem.read_data : inst[23:8];

	assign need_upper = !fresh && !upper_pend && !op_pend && inst_len(opcode) == 2'd3;
	assign need_operand = upper_pend && opcode == OP_LD_XL_DIR;
	assign execute = !fresh && !need_upper && !need_operand;
	assign trap = execute && opcode == OP_TRAP;

	always_comb
	begin
		case (opcode)
			OP_JR: taken = 1'b1;
			OP_JRZ: taken = f[FLAG_Z];
			OP_JRNZ: taken = !f[FLAG_Z];
			OP_JRC: taken = f[FLAG_C];
			OP_JRNC: taken = !f[FLAG_C];
			default: taken = 1'b0;
		endcase
	end

	always_comb
	begin
		// trap holds pc, so the same instruction keeps executing
		if (!execute || opcode == OP_TRAP)
			next_pc = pc;
		else if (taken)
			next_pc = pc + {{8{inst[15]}}, inst[15:8]};
		else
			next_pc = pc + word_t'(inst_len(opcode));

		if (need_upper)
			mem.read_addr = pc + 16'd1;
		else if (need_operand)
			mem.read_addr = inst[23:8];
		else
			mem.read_addr = next_pc;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= RESET_PC;
			fresh <= 1'b1;
			upper_pend <= 1'b0;
			op_pend <= 1'b0;
			saved <= {16'h0000, OP_NOP};
		end
		else
		begin
			pc <= next_pc;
			fresh <= 1'b0;
			upper_pend <= need_upper;
			op_pend <= need_operand;
			if (need_upper || need_operand)
				saved <= inst;
		end
	end

endmodule

//--- source/register_file.sv
`timescale 1ns/1ps

module register_file (
	input logic clk,
	input logic reset,
	input logic [1:0] reg_addr,
	input cpu_pkg::word_t reg_data,
	input logic [1:0] reg_en,
	input cpu_pkg::byte_t next_f,
	output cpu_pkg::word_t x,
	output cpu_pkg::word_t y,
	output cpu_pkg::byte_t f
);
	import cpu_pkg::*;

	// x, y, z
	word_t regs [3];

	assign x = regs[0];
	assign y = regs[1];

	// nothing loads the x high byte, so it keeps its reset value
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			regs[0] <= '0;
			regs[1] <= '0;
			regs[2] <= '0;
		end
		else
		begin
			if (reg_en[0])
				regs[reg_addr][7:0] <= reg_data[7:0];
			if (reg_en[1])
				regs[reg_addr][15:8] <= reg_data[15:8];
		end
	end

	// upper flag bits are unused
	always_ff @(posedge clk)
	begin
		if (reset)
			f <= {3'b000, next_f[4:0]};
		else
			f <= next_f;
	end

endmodule

//--- source/mem_lanes.sv
`timescale 1ns/1ps

module mem_lanes (
	input logic clk,
	mem_req_if.lanes mem,
	output cpu_pkg::bank_addr_t read_addr_even,
	output cpu_pkg::bank_addr_t read_addr_odd,
	input cpu_pkg::byte_t read_data_even,
	input cpu_pkg::byte_t read_data_odd,
	output cpu_pkg::bank_addr_t write_addr_even,
	output cpu_pkg::bank_addr_t write_addr_odd,
	output cpu_pkg::byte_t write_data_even,
	output cpu_pkg::byte_t write_data_odd,
	output logic write_en_even,
	output logic write_en_odd
);
	import cpu_pkg::*;

	bank_addr_t read_base;
	bank_addr_t write_base;
	logic read_odd_q;

	assign read_base = mem.read_addr[15:1];
	assign write_base = mem.write_addr[15:1];

	// odd start address: the second byte sits in the next even word
	assign read_addr_odd = read_base;
	assign read_addr_even = mem.read_addr[0] ? read_base + 15'd1 : read_base;

	// banks answer one cycle later, so the parity has to follow
	always_ff @(posedge clk)
		read_odd_q <= mem.read_addr[0];

	assign mem.read_data = read_odd_q ? {read_data_even, read_data_odd}
		: {read_data_odd, read_data_even};

	assign write_addr_odd = write_base;
	assign write_addr_even = mem.write_addr[0] ? write_base + 15'd1 : write_base;
	assign write_data_even = mem.write_addr[0] ? mem.write_data[15:8] : mem.write_data[7:0];
	assign write_data_odd = mem.write_addr[0] ? mem.write_data[7:0] : mem.write_data[15:8];
	assign write_en_even = mem.write_addr[0] ? mem.write_en[1] : mem.write_en[0];
	assign write_en_odd = mem.write_addr[0] ? mem.write_en[0] : mem.write_en[1];

endmodule

//--- source/mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if;
	import cpu_pkg::*;

	word_t read_addr;
	// bytes at the previous read_addr, low byte first
	word_t read_data;
	word_t write_addr;
	word_t write_data;
	// bit 0 low byte, bit 1 high byte
	logic [1:0] write_en;

	modport fetch (output read_addr, input read_data);
	modport exec (output write_addr, output write_data, output write_en);
	modport lanes (input read_addr, output read_data,
		input write_addr, input write_data, input write_en);

endinterface

//--- source/cpu_pkg.sv
package cpu_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] word_t;
	typedef logic [14:0] bank_addr_t;

	// opcode in bits 7:0, operand bytes above it
	typedef logic [23:0] inst_t;

	typedef enum logic [7:0]
	{
		OP_NOP = 8'h00,
		OP_TRAP = 8'h01,
		OP_INC_XL = 8'h02,
		OP_SRL_XL = 8'h03,
		OP_ADDW_Y_X = 8'h04,
		OP_LD_XL_IMM = 8'h10,
		OP_ADD_XL_IMM = 8'h11,
		OP_SUB_XL_IMM = 8'h12,
		OP_AND_XL_IMM = 8'h13,
		OP_OR_XL_IMM = 8'h14,
		OP_XOR_XL_IMM = 8'h15,
		OP_JR = 8'h20,
		OP_JRZ = 8'h21,
		OP_JRNZ = 8'h22,
		OP_JRC = 8'h23,
		OP_JRNC = 8'h24,
		OP_LD_XL_DIR = 8'h30,
		OP_LD_DIR_XL = 8'h31,
		OP_LDW_Y_IMM = 8'h32,
		OP_LDW_DIR_Y = 8'h33
	} opcode_t;

	// bit positions in the flag register
	typedef enum logic [2:0]
	{
		FLAG_H,
		FLAG_C,
		FLAG_N,
		FLAG_Z,
		FLAG_O,
		FLAG_5,
		FLAG_6,
		FLAG_7
	} flag_t;

	typedef enum logic [3:0]
	{
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_INC,
		ALU_SRL,
		ALU_ADDW,
		ALU_PASS
	} alu_op_t;

	// unknown opcodes are one byte long and behave as nop
	function automatic logic [1:0] inst_len(opcode_t op);
		case (op)
			OP_LD_XL_IMM, OP_ADD_XL_IMM, OP_SUB_XL_IMM, OP_AND_XL_IMM,
			OP_OR_XL_IMM, OP_XOR_XL_IMM, OP_JR, OP_JRZ, OP_JRNZ, OP_JRC, OP_JRNC:
				return 2'd2;
			OP_LD_XL_DIR, OP_LD_DIR_XL, OP_LDW_Y_IMM, OP_LDW_DIR_Y:
				return 2'd3;
			default:
				return 2'd1;
		endcase
	endfunction

endpackage
